/* csr_regs.sv */
`timescale 1ns/1ps

module csr_regs (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   csr_wr,
   input  eth_cls_pkg::csr_addr_e csr_addr,
   input  logic [31:0]            csr_wdata,
   output eth_cls_pkg::cls_csr_t  csr
);

   // ----------------------------------------
   // Configuration write port
   // ----------------------------------------

   // Everything zero after reset, so the classifier starts disabled
   always_ff @(posedge clk) begin
      if (rst) begin
         csr <= '0;
      end else if (csr_wr) begin
         case (csr_addr)
            // Upper MAC bits sit in the low half of the word
            eth_cls_pkg::MAC_HI: begin
               csr.mac[47:32] <= csr_wdata[15:0];
            end
            eth_cls_pkg::MAC_LO: begin
               csr.mac[31:0] <= csr_wdata;
            end
            eth_cls_pkg::IP_ADDR: begin
               csr.ip <= csr_wdata;
            end
            // UDP destination ports to match
            eth_cls_pkg::UDP0: begin
               csr.udp0 <= csr_wdata[15:0];
            end
            eth_cls_pkg::UDP1: begin
               csr.udp1 <= csr_wdata[15:0];
            end
            // Control bits
            // bit 0 enable, bits 1/2 port enables, bit 3 DRaT exposure
            eth_cls_pkg::CTRL: begin
               csr.enable      <= csr_wdata[0];
               csr.udp0_en     <= csr_wdata[1];
               csr.udp1_en     <= csr_wdata[2];
               csr.expose_drat <= csr_wdata[3];
            end
            // Unmapped addresses are ignored
            default: begin
               csr <= csr;
            end
         endcase
      end
   end

endmodule

/* egress_fifo.sv */
`timescale 1ns/1ps
`include "eth_cls_cfg.svh"

module egress_fifo #(
   parameter int AW = `ETH_FIFO_AW
) (
   input  logic                   clk,
   input  logic                   rst,
   input  eth_cls_pkg::eth_beat_t in_beat,
   input  logic                   in_valid,
   output logic                   in_ready,
   output eth_cls_pkg::eth_beat_t out_beat,
   output logic                   out_valid,
   input  logic                   out_ready
);

   localparam int DEPTH = 1 << AW;

   eth_cls_pkg::eth_beat_t mem [0:DEPTH-1];
   logic [AW-1:0]          wr_ptr;
   logic [AW-1:0]          rd_ptr;
   // Entries held, 0 to DEPTH
   logic [AW:0]            count;
   logic                   wr_en;
   logic                   rd_en;

   // ----------------------------------------
   // Handshake
   // ----------------------------------------

   // Top count bit is set only when every entry is used
   always_comb begin
      in_ready  = !count[AW];
      out_valid = (count != '0);
      out_beat  = mem[rd_ptr];
      wr_en     = in_valid && in_ready;
      rd_en     = out_valid && out_ready;
   end

   // Storage
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= in_beat;
      end
   end

   // Pointers wrap on their own width
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // Simultaneous push and pop leave the count alone
         if (wr_en && !rd_en) begin
            count <= count + 1'b1;
         end else if (rd_en && !wr_en) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

/* eth_classifier_2_egress.sv */
`timescale 1ns/1ps
`include "eth_cls_cfg.svh"

module eth_classifier_2_egress (
   input  logic                   clk,
   input  logic                   rst,
   input  eth_cls_pkg::cls_csr_t  csr,
   // Ingress stream
   input  eth_cls_pkg::eth_beat_t in_beat,
   input  logic                   in_valid,
   output logic                   in_ready,
   // Egress 0, everything not for us
   output eth_cls_pkg::eth_beat_t out0_beat,
   output logic                   out0_valid,
   input  logic                   out0_ready,
   // Egress 1, our UDP traffic with headers stripped
   output eth_cls_pkg::eth_beat_t out1_beat,
   output logic                   out1_valid,
   input  logic                   out1_ready
);

   localparam logic [3:0] HDR_LAST   = 4'(`ETH_HDR_BEATS - 1);
   // Replay start for egress 1, IPv4 header or DRaT payload
   localparam logic [3:0] START_L3   = 4'd2;
   localparam logic [3:0] START_DRAT = 4'd6;

   eth_cls_pkg::cls_state_e state;
   eth_cls_pkg::cls_flags_t flags;

   // Header buffer, written and replayed through one address
   eth_cls_pkg::eth_beat_t  hdr_buf [0:`ETH_HDR_BEATS-1];
   logic [3:0]              hdr_addr;
   // Index of the last stored header beat
   logic [3:0]              hdr_end;
   // Header capture finished, waiting one edge for the flags
   logic                    hdr_full;
   logic                    hdr_accept;
   // Replay done, beats now come straight from the input
   logic                    fwd_input;
   logic                    forwarding;
   logic [3:0]              start_idx;

   // Beat heading for the selected egress
   eth_cls_pkg::eth_beat_t  cur_beat;
   logic                    cur_valid;
   logic                    cur_ready;
   logic                    cur_xfer;
   logic                    fifo0_valid;
   logic                    fifo0_ready;
   logic                    fifo1_valid;
   logic                    fifo1_ready;

   // ----------------------------------------
   // Steering and handshake
   // ----------------------------------------

   always_comb begin
      forwarding = (state == eth_cls_pkg::FORWARD_0) ||
                   (state == eth_cls_pkg::FORWARD_1) ||
                   (state == eth_cls_pkg::DROP_FRAME);
      start_idx  = csr.expose_drat ? START_DRAT : START_L3;
      cur_beat   = fwd_input ? in_beat : hdr_buf[hdr_addr];
      cur_valid  = forwarding && (!fwd_input || in_valid);
      // Dropped frames drain at full rate
      case (state)
         eth_cls_pkg::DROP_FRAME: cur_ready = 1'b1;
         eth_cls_pkg::FORWARD_0:  cur_ready = fifo0_ready;
         eth_cls_pkg::FORWARD_1:  cur_ready = fifo1_ready;
         default:                 cur_ready = 1'b0;
      endcase
      cur_xfer    = cur_valid && cur_ready;
      // Only the chosen FIFO sees valid
      fifo0_valid = cur_valid && (state == eth_cls_pkg::FORWARD_0);
      fifo1_valid = cur_valid && (state == eth_cls_pkg::FORWARD_1);
      in_ready    = (state == eth_cls_pkg::WAIT_FRAME) ||
                    ((state == eth_cls_pkg::READ_HEADER) && !hdr_full) ||
                    (fwd_input && cur_ready);
      hdr_accept  = in_valid && in_ready &&
                    ((state == eth_cls_pkg::WAIT_FRAME) ||
                     (state == eth_cls_pkg::READ_HEADER));
   end

   // Header capture
   always_ff @(posedge clk) begin
      if (hdr_accept) begin
         hdr_buf[hdr_addr] <= in_beat;
      end
   end

   // ----------------------------------------
   // Forwarding FSM
   // ----------------------------------------

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= eth_cls_pkg::WAIT_FRAME;
         hdr_addr  <= '0;
         hdr_end   <= '0;
         hdr_full  <= 1'b0;
         fwd_input <= 1'b0;
      end else begin
         // Header beats land here in WAIT_FRAME and READ_HEADER
         if (hdr_accept) begin
            hdr_end <= hdr_addr;
            if (in_beat.last || (hdr_addr == HDR_LAST)) begin
               hdr_full <= 1'b1;
            end else begin
               hdr_addr <= hdr_addr + 4'd1;
            end
         end
         case (state)
            eth_cls_pkg::WAIT_FRAME: begin
               if (hdr_accept) begin
                  state <= eth_cls_pkg::READ_HEADER;
               end
            end
            // Hold off one edge once full so the inspector settles
            eth_cls_pkg::READ_HEADER: begin
               if (hdr_full) begin
                  hdr_full <= 1'b0;
                  state    <= eth_cls_pkg::CLASSIFY;
               end
            end
            // Route decision
            eth_cls_pkg::CLASSIFY: begin
               hdr_addr <= '0;
               if (!csr.enable) begin
                  state <= eth_cls_pkg::DROP_FRAME;
               end else if (flags.icmp || flags.bcast || flags.mcast) begin
                  state <= eth_cls_pkg::FORWARD_0;
               end else if (flags.mac_hit && flags.ip_hit && (|flags.port_hit)) begin
                  // Nothing left past the strip point means an empty frame
                  if (start_idx > hdr_end) begin
                     state <= eth_cls_pkg::DROP_FRAME;
                  end else begin
                     state    <= eth_cls_pkg::FORWARD_1;
                     hdr_addr <= start_idx;
                  end
               end else begin
                  state <= eth_cls_pkg::FORWARD_0;
               end
            end
            // Replay the buffer, then pass the input through
            eth_cls_pkg::FORWARD_0, eth_cls_pkg::FORWARD_1, eth_cls_pkg::DROP_FRAME: begin
               if (cur_xfer) begin
                  if (cur_beat.last) begin
                     state     <= eth_cls_pkg::WAIT_FRAME;
                     hdr_addr  <= '0;
                     fwd_input <= 1'b0;
                  end else if (!fwd_input) begin
                     if (hdr_addr == HDR_LAST) begin
                        fwd_input <= 1'b1;
                     end else begin
                        hdr_addr <= hdr_addr + 4'd1;
                     end
                  end
               end
            end
            // Unused encodings fall back to idle
            default: begin
               state     <= eth_cls_pkg::WAIT_FRAME;
               hdr_addr  <= '0;
               fwd_input <= 1'b0;
            end
         endcase
      end
   end

   // ----------------------------------------
   // Inspector and egress FIFOs
   // ----------------------------------------

   header_inspector u_inspector (
      .clk      (clk),
      .rst      (rst),
      .beat     (in_beat),
      .accept   (hdr_accept),
      .beat_idx (hdr_addr),
      .csr      (csr),
      .flags    (flags)
   );

   egress_fifo #(
      .AW (`ETH_FIFO_AW)
   ) u_fifo0 (
      .clk       (clk),
      .rst       (rst),
      .in_beat   (cur_beat),
      .in_valid  (fifo0_valid),
      .in_ready  (fifo0_ready),
      .out_beat  (out0_beat),
      .out_valid (out0_valid),
      .out_ready (out0_ready)
   );

   egress_fifo #(
      .AW (`ETH_FIFO_AW)
   ) u_fifo1 (
      .clk       (clk),
      .rst       (rst),
      .in_beat   (cur_beat),
      .in_valid  (fifo1_valid),
      .in_ready  (fifo1_ready),
      .out_beat  (out1_beat),
      .out_valid (out1_valid),
      .out_ready (out1_ready)
   );

endmodule

/* eth_classifier_properties.sv */
`timescale 1ns/1ps

module eth_classifier_properties (
   input logic                    clk,
   input logic                    rst,
   input eth_cls_pkg::cls_state_e state,
   input eth_cls_pkg::eth_beat_t  cur_beat,
   input logic                    fifo0_valid,
   input logic                    fifo0_ready,
   input logic                    fifo1_valid,
   input logic                    fifo1_ready,
   input eth_cls_pkg::eth_beat_t  out0_beat,
   input logic                    out0_valid,
   input logic                    out0_ready,
   input eth_cls_pkg::eth_beat_t  out1_beat,
   input logic                    out1_valid,
   input logic                    out1_ready
);

   // Failed checks, read back at the end of the run
   int unsigned fail_count = 0;

   // ----------------------------------------
   // Stream stability under stall
   // ----------------------------------------

   // FIFO write side held while the FIFO is full
   hold_fifo0: assert property (@(posedge clk) disable iff (rst)
      fifo0_valid && !fifo0_ready |=> fifo0_valid && $stable(cur_beat))
   else begin
      fail_count++;
      $error("Egress 0 FIFO input changed while stalled");
   end

   hold_fifo1: assert property (@(posedge clk) disable iff (rst)
      fifo1_valid && !fifo1_ready |=> fifo1_valid && $stable(cur_beat))
   else begin
      fail_count++;
      $error("Egress 1 FIFO input changed while stalled");
   end

   // Egress ports themselves
   hold_out0: assert property (@(posedge clk) disable iff (rst)
      out0_valid && !out0_ready |=> out0_valid && $stable(out0_beat))
   else begin
      fail_count++;
      $error("out0 beat changed while stalled");
   end

   hold_out1: assert property (@(posedge clk) disable iff (rst)
      out1_valid && !out1_ready |=> out1_valid && $stable(out1_beat))
   else begin
      fail_count++;
      $error("out1 beat changed while stalled");
   end

   // ----------------------------------------
   // FSM use
   // ----------------------------------------

   // Dropped frames never touch a FIFO
   no_drop_write: assert property (@(posedge clk) disable iff (rst)
      state == eth_cls_pkg::DROP_FRAME |-> !fifo0_valid && !fifo1_valid)
   else begin
      fail_count++;
      $error("FIFO written during DROP_FRAME");
   end

   classify_once: assert property (@(posedge clk) disable iff (rst)
      state == eth_cls_pkg::CLASSIFY |=> state != eth_cls_pkg::CLASSIFY)
   else begin
      fail_count++;
      $error("CLASSIFY held for more than one cycle");
   end

endmodule

bind eth_classifier_2_egress eth_classifier_properties u_props (
   .clk         (clk),
   .rst         (rst),
   .state       (state),
   .cur_beat    (cur_beat),
   .fifo0_valid (fifo0_valid),
   .fifo0_ready (fifo0_ready),
   .fifo1_valid (fifo1_valid),
   .fifo1_ready (fifo1_ready),
   .out0_beat   (out0_beat),
   .out0_valid  (out0_valid),
   .out0_ready  (out0_ready),
   .out1_beat   (out1_beat),
   .out1_valid  (out1_valid),
   .out1_ready  (out1_ready)
);

/* eth_classifier_top.sv */
`timescale 1ns/1ps

module eth_classifier_top (
   input  logic                   clk,
   input  logic                   rst,
   // CSR write side
   input  logic                   csr_wr,
   input  eth_cls_pkg::csr_addr_e csr_addr,
   input  logic [31:0]            csr_wdata,
   // Ingress stream
   input  eth_cls_pkg::eth_beat_t in_beat,
   input  logic                   in_valid,
   output logic                   in_ready,
   // Egress streams
   output eth_cls_pkg::eth_beat_t out0_beat,
   output logic                   out0_valid,
   input  logic                   out0_ready,
   output eth_cls_pkg::eth_beat_t out1_beat,
   output logic                   out1_valid,
   input  logic                   out1_ready
);

   // Live configuration into the datapath
   eth_cls_pkg::cls_csr_t csr;

   csr_regs u_csr (
      .clk       (clk),
      .rst       (rst),
      .csr_wr    (csr_wr),
      .csr_addr  (csr_addr),
      .csr_wdata (csr_wdata),
      .csr       (csr)
   );

   eth_classifier_2_egress u_cls (
      .clk        (clk),
      .rst        (rst),
      .csr        (csr),
      .in_beat    (in_beat),
      .in_valid   (in_valid),
      .in_ready   (in_ready),
      .out0_beat  (out0_beat),
      .out0_valid (out0_valid),
      .out0_ready (out0_ready),
      .out1_beat  (out1_beat),
      .out1_valid (out1_valid),
      .out1_ready (out1_ready)
   );

endmodule

/* eth_cls_cfg.svh */
`ifndef ETH_CLS_CFG_SVH
`define ETH_CLS_CFG_SVH

// ----------------------------------------
// Datapath sizing
// ----------------------------------------

// Payload bits per stream beat
`define ETH_DATA_W 64

// Header beats held for inspection and replay
`define ETH_HDR_BEATS 9

// Egress FIFO address width, 32 entries
`define ETH_FIFO_AW 5

// ----------------------------------------
// Protocol constants
// ----------------------------------------

`define ETH_TYPE_IPV4 16'h0800
`define ETH_PROTO_UDP 8'h11
`define ETH_PROTO_ICMP 8'h01

`endif

/* eth_cls_pkg.sv */
`include "eth_cls_cfg.svh"

package eth_cls_pkg;

   // One stream beat with its end-of-frame marker
   typedef struct packed {
      logic                   last;
      logic [`ETH_DATA_W-1:0] data;
   } eth_beat_t;

   // Classification results built up while the header streams in
   typedef struct packed {
      logic       mac_hit;
      logic       bcast;
      logic       mcast;
      logic       ipv4;
      logic       icmp;
      logic       udp;
      logic       ip_hit;
      logic [1:0] port_hit;
   } cls_flags_t;

   // Local addresses and control bits
   typedef struct packed {
      logic [47:0] mac;
      logic [31:0] ip;
      logic [15:0] udp0;
      logic [15:0] udp1;
      logic        udp0_en;
      logic        udp1_en;
      logic        expose_drat;
      logic        enable;
   } cls_csr_t;

   // Forwarding FSM
   typedef enum logic [2:0] {
      WAIT_FRAME,
      READ_HEADER,
      CLASSIFY,
      FORWARD_0,
      FORWARD_1,
      DROP_FRAME
   } cls_state_e;

   // Register map of the CSR write port
   typedef enum logic [2:0] {
      MAC_HI  = 3'd0,
      MAC_LO  = 3'd1,
      IP_ADDR = 3'd2,
      UDP0    = 3'd3,
      UDP1    = 3'd4,
      CTRL    = 3'd5
   } csr_addr_e;

endpackage

/* header_inspector.sv */
`timescale 1ns/1ps
`include "eth_cls_cfg.svh"

module header_inspector (
   input  logic                    clk,
   input  logic                    rst,
   input  eth_cls_pkg::eth_beat_t  beat,
   input  logic                    accept,
   input  logic [3:0]              beat_idx,
   input  eth_cls_pkg::cls_csr_t   csr,
   output eth_cls_pkg::cls_flags_t flags
);

   // Captured header beat and its position in the frame
   logic [`ETH_DATA_W-1:0] data_q;
   logic [3:0]             idx_q;
   // High for one cycle after each accepted header beat
   logic                   eval_q;

   // ----------------------------------------
   // Capture stage
   // ----------------------------------------

   always_ff @(posedge clk) begin
      if (accept) begin
         data_q <= beat.data;
         idx_q  <= beat_idx;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         eval_q <= 1'b0;
      end else begin
         eval_q <= accept;
      end
   end

   // ----------------------------------------
   // Field checks by beat position
   // ----------------------------------------

   // Later checks lean on earlier flags, so a frame only
   // collects UDP flags after the IPv4 ethertype matched
   always_ff @(posedge clk) begin
      if (rst) begin
         flags <= '0;
      end else if (eval_q) begin
         case (idx_q)
            // New frame
            // start over and look at upper 16 MAC bits
            4'd0: begin
               flags.mac_hit  <= (data_q[15:0] == csr.mac[47:32]);
               flags.bcast    <= (data_q[15:0] == 16'hFFFF);
               flags.mcast    <= data_q[8];
               flags.ipv4     <= 1'b0;
               flags.icmp     <= 1'b0;
               flags.udp      <= 1'b0;
               flags.ip_hit   <= 1'b0;
               flags.port_hit <= 2'b00;
            end
            // Lower 32 MAC bits finish both address matches
            4'd1: begin
               flags.mac_hit <= flags.mac_hit && (data_q[63:32] == csr.mac[31:0]);
               flags.bcast   <= flags.bcast && (data_q[63:32] == 32'hFFFF_FFFF);
            end
            // Ethertype
            4'd2: begin
               flags.ipv4 <= (data_q[47:32] == `ETH_TYPE_IPV4);
            end
            // IPv4 protocol field
            4'd3: begin
               flags.udp  <= flags.ipv4 && (data_q[23:16] == `ETH_PROTO_UDP);
               flags.icmp <= flags.ipv4 && (data_q[23:16] == `ETH_PROTO_ICMP);
            end
            // IPv4 destination address
            4'd4: begin
               flags.ip_hit <= flags.ipv4 && (data_q[31:0] == csr.ip);
            end
            // UDP destination port against both enabled ports
            4'd5: begin
               flags.port_hit[0] <= flags.udp && csr.udp0_en &&
                                    (data_q[47:32] == csr.udp0);
               flags.port_hit[1] <= flags.udp && csr.udp1_en &&
                                    (data_q[47:32] == csr.udp1);
            end
            // Beats 6 to 8 carry nothing we key on
            default: begin
               flags <= flags;
            end
         endcase
      end
   end

endmodule

/* list.f */
+incdir+.
eth_cls_pkg.sv
csr_regs.sv
header_inspector.sv
egress_fifo.sv
eth_classifier_2_egress.sv
eth_classifier_top.sv
eth_classifier_properties.sv
tb_eth_classifier.sv

/* tb_eth_classifier.sv */
`timescale 1ns/1ps
`include "eth_cls_cfg.svh"

module tb_eth_classifier;

   localparam int BEAT_LIMIT  = 2000;
   localparam int DRAIN_LIMIT = 5000;

   // Local station addresses and some foreign ones
   localparam logic [47:0] OUR_MAC   = 48'h0A12_3456_789A;
   localparam logic [47:0] OTHER_MAC = 48'h0A12_3456_0000;
   localparam logic [47:0] BCAST_MAC = 48'hFFFF_FFFF_FFFF;
   // Bit 40 set, group address
   localparam logic [47:0] MCAST_MAC = 48'h0113_0000_0042;
   localparam logic [31:0] OUR_IP    = 32'hC0A8_0105;
   localparam logic [15:0] PORT0     = 16'h1388;
   localparam logic [15:0] PORT1     = 16'h2000;
   localparam logic [15:0] TYPE_IPV6 = 16'h86DD;

   logic                   clk;
   logic                   rst;
   logic                   csr_wr;
   eth_cls_pkg::csr_addr_e csr_addr;
   logic [31:0]            csr_wdata;
   eth_cls_pkg::eth_beat_t in_beat;
   logic                   in_valid;
   logic                   in_ready;
   eth_cls_pkg::eth_beat_t out0_beat;
   logic                   out0_valid;
   logic                   out0_ready;
   eth_cls_pkg::eth_beat_t out1_beat;
   logic                   out1_valid;
   logic                   out1_ready;

   // Expected beats per egress port, in order
   eth_cls_pkg::eth_beat_t exp0 [$];
   eth_cls_pkg::eth_beat_t exp1 [$];

   // Mirror of the control bits for the routing model
   logic        m_enable = 1'b0;
   logic        m_udp0_en = 1'b0;
   logic        m_udp1_en = 1'b0;
   logic        m_drat = 1'b0;

   logic [31:0] seed = 32'h7971_d5d3;
   logic [31:0] stall_seed = 32'h7971_d5d3;
   logic        stall_mode = 1'b0;
   string       test_name = "reset";
   int          mismatches = 0;
   int          unexpected = 0;
   int          timeouts = 0;
   int          assert_fails = 0;

   eth_classifier_top UUT (
      .clk        (clk),
      .rst        (rst),
      .csr_wr     (csr_wr),
      .csr_addr   (csr_addr),
      .csr_wdata  (csr_wdata),
      .in_beat    (in_beat),
      .in_valid   (in_valid),
      .in_ready   (in_ready),
      .out0_beat  (out0_beat),
      .out0_valid (out0_valid),
      .out0_ready (out0_ready),
      .out1_beat  (out1_beat),
      .out1_valid (out1_valid),
      .out1_ready (out1_ready)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // ----------------------------------------
   // Helpers
   // ----------------------------------------

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [31:0] next_random();
      seed = lcg_step(seed);
      return seed;
   endfunction

   // One-cycle strobe, mirror updated alongside
   task automatic write_csr(input eth_cls_pkg::csr_addr_e addr, input logic [31:0] data);
      @(negedge clk);
      csr_wr    = 1'b1;
      csr_addr  = addr;
      csr_wdata = data;
      @(negedge clk);
      csr_wr = 1'b0;
      if (addr == eth_cls_pkg::CTRL) begin
         m_enable  = data[0];
         m_udp0_en = data[1];
         m_udp1_en = data[2];
         m_drat    = data[3];
      end
   endtask

   // Routing rule, -1 for a dropped frame
   function automatic int expected_port(input logic [47:0] dst, input logic [15:0] etype,
         input logic [7:0] proto, input logic [31:0] dip, input logic [15:0] dport,
         input int len);
      logic ipv4;
      logic udp;
      logic icmp;
      logic bcast;
      logic mcast;
      logic for_us;
      ipv4   = (len > 2) && (etype == `ETH_TYPE_IPV4);
      udp    = (len > 3) && ipv4 && (proto == `ETH_PROTO_UDP);
      icmp   = (len > 3) && ipv4 && (proto == `ETH_PROTO_ICMP);
      bcast  = (dst == 48'hFFFF_FFFF_FFFF);
      mcast  = dst[40];
      // Port field sits in beat 5, so runts never qualify
      for_us = (len >= 6) && (dst == OUR_MAC) && udp && (dip == OUR_IP) &&
               ((m_udp0_en && (dport == PORT0)) || (m_udp1_en && (dport == PORT1)));
      if (!m_enable) begin
         return -1;
      end else if (icmp || bcast || mcast) begin
         return 0;
      end else if (for_us) begin
         return 1;
      end
      return 0;
   endfunction

   // Build a frame by the layout rule, queue what must come out, then drive it
   task automatic send_frame(input logic [47:0] dst, input logic [15:0] etype,
         input logic [7:0] proto, input logic [31:0] dip, input logic [15:0] dport,
         input int len);
      eth_cls_pkg::eth_beat_t beats [$];
      eth_cls_pkg::eth_beat_t b;
      int i;
      int port;
      int first;
      int cnt;
      logic taken;
      for (i = 0; i < len; i++) begin
         b.data[63:32] = next_random();
         b.data[31:0]  = next_random();
         b.last        = (i == len - 1);
         case (i)
            0: b.data[15:0]  = dst[47:32];
            1: b.data[63:32] = dst[31:0];
            2: b.data[47:32] = etype;
            3: b.data[23:16] = proto;
            4: b.data[31:0]  = dip;
            5: b.data[47:32] = dport;
            default: b.data = b.data;
         endcase
         beats.push_back(b);
      end
      port  = expected_port(dst, etype, proto, dip, dport, len);
      // Stripped headers on egress 1
      first = (port == 1) ? (m_drat ? 6 : 2) : 0;
      for (i = first; i < len; i++) begin
         if (port == 0) begin
            exp0.push_back(beats[i]);
         end else if (port == 1) begin
            exp1.push_back(beats[i]);
         end
      end
      for (i = 0; i < len; i++) begin
         @(negedge clk);
         in_valid = 1'b1;
         in_beat  = beats[i];
         cnt      = 0;
         taken    = 1'b0;
         while (!taken && cnt < BEAT_LIMIT) begin
            @(posedge clk);
            taken = in_ready;
            cnt++;
         end
         if (!taken) begin
            timeouts++;
            $display("Timeout in test %s: beat %0d of a frame was never accepted",
                     test_name, i);
            break;
         end
      end
      @(negedge clk);
      in_valid = 1'b0;
   endtask

   // Wait for both queues to empty, then idle to catch stray beats
   task automatic drain_and_settle();
      int cnt;
      cnt = 0;
      while ((exp0.size() != 0 || exp1.size() != 0) && cnt < DRAIN_LIMIT) begin
         @(negedge clk);
         cnt++;
      end
      if (exp0.size() != 0 || exp1.size() != 0) begin
         timeouts++;
         $display("Timeout in test %s: %0d beats on out0 and %0d on out1 never arrived",
                  test_name, exp0.size(), exp1.size());
         exp0.delete();
         exp1.delete();
      end
      repeat (20) @(negedge clk);
   endtask

   task automatic check_beat(input int port, input eth_cls_pkg::eth_beat_t act);
      eth_cls_pkg::eth_beat_t exp;
      if ((port == 0 && exp0.size() == 0) || (port == 1 && exp1.size() == 0)) begin
         unexpected++;
         $display("Unexpected beat on out%0d in test %s: %h", port, test_name, act);
      end else begin
         if (port == 0) begin
            exp = exp0.pop_front();
         end else begin
            exp = exp1.pop_front();
         end
         assert (act == exp) else begin
            mismatches++;
            $display("[ERROR] %s out%0d: expected %h, actual %h", test_name, port, exp, act);
         end
      end
   endtask

   // ----------------------------------------
   // Egress monitors and back-pressure
   // ----------------------------------------

   always @(posedge clk) begin
      if (!rst && out0_valid && out0_ready) begin
         check_beat(0, out0_beat);
      end
      if (!rst && out1_valid && out1_ready) begin
         check_beat(1, out1_beat);
      end
   end

   // Ready about a quarter of the time while stalling
   initial begin
      out0_ready = 1'b1;
      out1_ready = 1'b1;
      forever begin
         @(negedge clk);
         if (stall_mode) begin
            stall_seed = lcg_step(stall_seed);
            out0_ready = (stall_seed[31:30] == 2'b00);
            out1_ready = (stall_seed[29:28] == 2'b00);
         end else begin
            out0_ready = 1'b1;
            out1_ready = 1'b1;
         end
      end
   end

   // ----------------------------------------
   // Test sequence
   // ----------------------------------------

   initial begin
      logic [31:0] r;
      int          kind;
      int          len;
      rst       = 1'b1;
      csr_wr    = 1'b0;
      csr_addr  = eth_cls_pkg::MAC_HI;
      csr_wdata = '0;
      in_valid  = 1'b0;
      in_beat   = '0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      // CSRs still zero, everything is swallowed
      test_name = "disabled";
      send_frame(OUR_MAC, `ETH_TYPE_IPV4, `ETH_PROTO_UDP, OUR_IP, PORT0, 10);
      send_frame(BCAST_MAC, `ETH_TYPE_IPV4, `ETH_PROTO_UDP, OUR_IP, PORT0, 8);
      send_frame(OTHER_MAC, TYPE_IPV6, 8'h06, 32'h0, 16'h0, 12);
      drain_and_settle();

      write_csr(eth_cls_pkg::MAC_HI, {16'h0, OUR_MAC[47:32]});
      write_csr(eth_cls_pkg::MAC_LO, OUR_MAC[31:0]);
      write_csr(eth_cls_pkg::IP_ADDR, OUR_IP);
      write_csr(eth_cls_pkg::UDP0, {16'h0, PORT0});
      write_csr(eth_cls_pkg::UDP1, {16'h0, PORT1});
      // Enable with port 0 only
      write_csr(eth_cls_pkg::CTRL, 32'h3);

      test_name = "for_us";
      send_frame(OUR_MAC, `ETH_TYPE_IPV4, `ETH_PROTO_UDP, OUR_IP, PORT0, 10);
      drain_and_settle();
      write_csr(eth_cls_pkg::CTRL, 32'hB);
      test_name = "expose_drat";
      send_frame(OUR_MAC, `ETH_TYPE_IPV4, `ETH_PROTO_UDP, OUR_IP, PORT0, 12);
      drain_and_settle();
      write_csr(eth_cls_pkg::CTRL, 32'h3);

      test_name = "to_out0";
      send_frame(BCAST_MAC, `ETH_TYPE_IPV4, `ETH_PROTO_UDP, OUR_IP, PORT0, 8);
      send_frame(MCAST_MAC, `ETH_TYPE_IPV4, `ETH_PROTO_UDP, OUR_IP, PORT0, 9);
      send_frame(OUR_MAC, `ETH_TYPE_IPV4, `ETH_PROTO_ICMP, OUR_IP, PORT0, 7);
      // Port 1 matches but is disabled
      send_frame(OUR_MAC, `ETH_TYPE_IPV4, `ETH_PROTO_UDP, OUR_IP, PORT1, 10);
      send_frame(OUR_MAC, TYPE_IPV6, `ETH_PROTO_UDP, OUR_IP, PORT0, 8);
      drain_and_settle();

      // Long frames pass through after replay, runts stay on out0
      test_name = "lengths";
      send_frame(OUR_MAC, `ETH_TYPE_IPV4, `ETH_PROTO_UDP, OUR_IP, PORT0, 15);
      send_frame(OUR_MAC, `ETH_TYPE_IPV4, `ETH_PROTO_UDP, OUR_IP, PORT0, 25);
      send_frame(OTHER_MAC, `ETH_TYPE_IPV4, `ETH_PROTO_UDP, OUR_IP, PORT0, 20);
      send_frame(OUR_MAC, `ETH_TYPE_IPV4, `ETH_PROTO_UDP, OUR_IP, PORT0, 1);
      send_frame(OUR_MAC, `ETH_TYPE_IPV4, `ETH_PROTO_UDP, OUR_IP, PORT0, 3);
      send_frame(OUR_MAC, `ETH_TYPE_IPV4, `ETH_PROTO_UDP, OUR_IP, PORT0, 5);
      drain_and_settle();

      // Mixed traffic under random egress back-pressure
      test_name = "stall";
      write_csr(eth_cls_pkg::CTRL, 32'h7);
      stall_mode = 1'b1;
      repeat (24) begin
         r    = next_random();
         kind = int'(r[7:0]) % 5;
         len  = 7 + int'(r[11:8]) % 12;
         case (kind)
            0: send_frame(OUR_MAC, `ETH_TYPE_IPV4, `ETH_PROTO_UDP, OUR_IP, PORT0, len);
            1: send_frame(OUR_MAC, `ETH_TYPE_IPV4, `ETH_PROTO_UDP, OUR_IP, PORT1, len);
            2: send_frame(BCAST_MAC, `ETH_TYPE_IPV4, `ETH_PROTO_UDP, OUR_IP, PORT0, len);
            3: send_frame(OUR_MAC, `ETH_TYPE_IPV4, `ETH_PROTO_ICMP, OUR_IP, PORT0, len);
            default: send_frame(OTHER_MAC, `ETH_TYPE_IPV4, `ETH_PROTO_UDP, OUR_IP, PORT0, len);
         endcase
      end
      drain_and_settle();
      stall_mode = 1'b0;

      assert_fails = UUT.u_cls.u_props.fail_count;
      $display("Error counts: mismatch %0d, unexpected %0d, timeout %0d, assertion %0d",
               mismatches, unexpected, timeouts, assert_fails);
      if (mismatches + unexpected + timeouts + assert_fails == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule
